//--- compile.f
+incdir+rtl
rtl/wrot_beat_pkg.sv
rtl/wrot_ctrl_pkg.sv
rtl/weight_bank_ram.sv
rtl/weight_loader.sv
rtl/weight_replayer.sv
rtl/weight_rotator_top.sv
dv/weight_rotator_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= weight_rotator_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS    := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG); grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/weight_rotator_tb.sv
`timescale 1ns/1ps
`include "wrot_cfg.svh"

module weight_rotator_tb
  import wrot_beat_pkg::*;
();

  localparam int BW        = `WROT_BEAT_WIDTH;
  localparam int UW        = `WROT_USER_WIDTH;
  localparam int NUM_XFERS = 6;
  localparam int TIMEOUT   = 200000;   // cycles per wait loop.

  logic          aclk;
  logic          rst_n;
  logic          s_valid;
  logic [BW-1:0] s_data;
  logic          s_credit;
  logic          m_valid;
  logic [BW-1:0] m_data;
  logic [UW-1:0] m_user;
  logic          m_last;
  logic          m_credit;

  logic [BW-1:0] in_q[$];       // beats still to send upstream.
  logic [BW-1:0] exp_data[$];
  logic [UW-1:0] exp_user[$];
  logic          exp_last[$];
  logic [BW-1:0] kernel[`WROT_BANK_DEPTH];
  int            errors;
  int            checked;
  int            up_credits;
  int            sent;
  int            credited;
  int            total_in;
  int            seen;
  int            returned;
  int            owed;
  int            stall;

  weight_rotator_top DUT (
    .aclk(aclk), .rst_n(rst_n), .s_valid(s_valid), .s_data(s_data), .s_credit(s_credit),
    .m_valid(m_valid), .m_data(m_data), .m_user(m_user), .m_last(m_last),
    .m_credit(m_credit)
  );

  always #2 aclk = ~aclk;

  task automatic check_value(input logic [BW-1:0] actual, input logic [BW-1:0] expected,
                             input string msg);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
    end
  endtask

  // expected output of one transfer, the kernel is taken from kernel[].
  function automatic void build_expected(input kh_t kh_1, input cin_t cin_1,
                                         input cols_t cols_1, input blocks_t blocks_1);
    logic [UW-1:0] user;
    int            n;
    n = (int'(kh_1) + 1) * (int'(cin_1) + 1);
    user = '0;
    user[user_config] = 1'b1;
    exp_data.push_back(BW'({blocks_1, cols_1, cin_1, kh_1}));
    exp_user.push_back(user);
    exp_last.push_back(1'b0);
    for (int b = 0; b <= int'(blocks_1); b++) begin
      for (int c = 0; c <= int'(cols_1); c++) begin
        for (int a = 0; a < n; a++) begin
          user = '0;
          user[user_top_block]    = (b == 0);
          user[user_bottom_block] = (b == int'(blocks_1));
          user[user_cin_last]     = (a / (int'(kh_1) + 1) == int'(cin_1));   // cin-major.
          user[user_cols_last]    = (c == int'(cols_1));
          exp_data.push_back(kernel[a]);
          exp_user.push_back(user);
          exp_last.push_back(b == int'(blocks_1) && c == int'(cols_1) && a == n - 1);
        end
      end
    end
  endfunction

  // upstream, spends a credit per beat and gets it back on s_credit.
  always @(posedge aclk) begin
    if (!rst_n) begin
      up_credits = `WROT_IN_CREDITS;
    end else begin
      if (s_credit) begin
        up_credits++;
        credited++;
        check_value(BW'(credited <= sent), BW'(1), "s_credit pulses exceed beats sent");
      end
      s_valid <= 1'b0;
      if (in_q.size() != 0 && up_credits > 0 && $urandom % 4 != 0) begin
        s_valid <= 1'b1;
        s_data  <= in_q.pop_front();
        up_credits--;
        sent++;
      end
    end
  end

  // downstream, returns credits late and stalls now and then.
  always @(posedge aclk) begin
    if (!rst_n) begin
      owed  = 0;
      stall = 0;
      m_credit <= 1'b0;
    end else begin
      if (m_valid) begin
        seen++;
        owed++;
        check_value(BW'(seen - returned <= `WROT_OUT_CREDITS), BW'(1),
                    "beats outstanding exceed output credits");
      end
      m_credit <= 1'b0;
      if (stall != 0) begin
        stall--;
      end else if ($urandom % 128 == 0) begin
        stall = 20 + $urandom % 150;
      end else if (owed != 0 && $urandom % 3 != 0) begin
        m_credit <= 1'b1;
        owed--;
        returned++;
      end
    end
  end

  // outputs settle by the falling edge.
  always @(negedge aclk) begin
    if (rst_n && m_valid) begin
      if (exp_data.size() == 0) begin
        errors++;
        $display("output beat at %0t arrived after every expected beat was seen", $time);
      end else begin
        check_value(m_data, exp_data.pop_front(), $sformatf("m_data of beat %0d", checked));
        check_value(BW'(m_user), BW'(exp_user.pop_front()),
                    $sformatf("m_user of beat %0d", checked));
        check_value(BW'(m_last), BW'(exp_last.pop_front()),
                    $sformatf("m_last of beat %0d", checked));
        checked++;
      end
    end
  end

  initial begin
    kh_t     kh;
    cin_t    cin;
    cols_t   cols;
    blocks_t blocks;
    int      cycles;
    void'($urandom(32'hc221));
    aclk     = 1'b0;
    rst_n    = 1'b0;
    s_valid  = 1'b0;
    s_data   = '0;
    m_credit = 1'b0;
    errors   = 0;
    checked  = 0;
    sent     = 0;
    credited = 0;
    seen     = 0;
    returned = 0;
    // first transfer is the smallest one, the rest are random.
    for (int x = 0; x < NUM_XFERS; x++) begin
      kh     = (x == 0) ? kh_t'(0) : kh_t'($urandom);
      cin    = (x == 0) ? cin_t'(0) : cin_t'($urandom);
      cols   = (x == 0) ? cols_t'(0) : cols_t'($urandom % 6);
      blocks = (x == 0) ? blocks_t'(0) : blocks_t'($urandom % 4);
      in_q.push_back(BW'({blocks, cols, cin, kh}));
      for (int a = 0; a < (int'(kh) + 1) * (int'(cin) + 1); a++) begin
        kernel[a] = {$urandom, $urandom, $urandom};
        in_q.push_back(kernel[a]);
      end
      build_expected(kh, cin, cols, blocks);
    end
    total_in = in_q.size();
    repeat (16) @(posedge aclk);
    rst_n <= 1'b1;

    cycles = 0;
    while (exp_data.size() != 0 && cycles < TIMEOUT) begin
      @(posedge aclk);
      cycles++;
    end
    if (exp_data.size() != 0) begin
      errors++;
      $display("timeout: %0d expected output beats never arrived", exp_data.size());
    end

    // let credits drain so that a stray extra beat is still caught.
    cycles = 0;
    while ((credited != total_in || seen != returned) && cycles < TIMEOUT) begin
      @(posedge aclk);
      cycles++;
    end
    if (credited != total_in) begin
      errors++;
      $display("timeout: only %0d of %0d input beats were credited back", credited, total_in);
    end
    if (seen != returned) begin
      errors++;
      $display("timeout: downstream still holds %0d output credits", seen - returned);
    end

    $display("beats checked %0d, input beats %0d, errors %0d", checked, total_in, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- rtl/weight_rotator_top.sv
`timescale 1ns/1ps
`include "wrot_cfg.svh"

module weight_rotator_top
  import wrot_beat_pkg::*;
(
  input  logic                        aclk,
  input  logic                        rst_n,
  input  logic                        s_valid,
  input  logic [`WROT_BEAT_WIDTH-1:0] s_data,
  output logic                        s_credit,
  output logic                        m_valid,
  output logic [`WROT_BEAT_WIDTH-1:0] m_data,
  output logic [`WROT_USER_WIDTH-1:0] m_user,
  output logic                        m_last,
  input  logic                        m_credit
);

  localparam int AW = $clog2(`WROT_BANK_DEPTH);

  logic                        wr_en;
  logic                        wr_bank;
  logic [AW-1:0]               wr_addr;
  logic [`WROT_BEAT_WIDTH-1:0] wr_data;
  logic                        rd_en;
  logic                        rd_bank;
  logic [AW-1:0]               rd_addr;
  logic [`WROT_BEAT_WIDTH-1:0] rd_data;
  logic [1:0]                  bank_ready;
  logic [1:0]                  bank_release;
  kh_t     [1:0]               hdr_kh_1;
  cin_t    [1:0]               hdr_cin_1;
  cols_t   [1:0]               hdr_cols_1;
  blocks_t [1:0]               hdr_blocks_1;

  weight_loader u_loader (
    .aclk, .rst_n, .s_valid, .s_data, .s_credit,
    .wr_en, .wr_bank, .wr_addr, .wr_data,
    .bank_ready, .hdr_kh_1, .hdr_cin_1, .hdr_cols_1, .hdr_blocks_1, .bank_release
  );

  weight_bank_ram u_ram (
    .aclk, .wr_en, .wr_bank, .wr_addr, .wr_data, .rd_en, .rd_bank, .rd_addr, .rd_data
  );

  weight_replayer u_replayer (
    .aclk, .rst_n, .bank_ready, .bank_release,
    .hdr_kh_1, .hdr_cin_1, .hdr_cols_1, .hdr_blocks_1,
    .rd_en, .rd_bank, .rd_addr, .rd_data,
    .m_credit, .m_valid, .m_data, .m_user, .m_last
  );

endmodule

//--- rtl/weight_replayer.sv
`timescale 1ns/1ps
`include "wrot_cfg.svh"

module weight_replayer
  import wrot_beat_pkg::*;
  import wrot_ctrl_pkg::*;
(
  input  logic                                aclk,
  input  logic                                rst_n,
  input  logic [1:0]                          bank_ready,
  output logic [1:0]                          bank_release,
  input  kh_t     [1:0]                       hdr_kh_1,
  input  cin_t    [1:0]                       hdr_cin_1,
  input  cols_t   [1:0]                       hdr_cols_1,
  input  blocks_t [1:0]                       hdr_blocks_1,
  output logic                                rd_en,
  output logic                                rd_bank,
  output logic [$clog2(`WROT_BANK_DEPTH)-1:0] rd_addr,
  input  logic [`WROT_BEAT_WIDTH-1:0]         rd_data,
  input  logic                                m_credit,
  output logic                                m_valid,
  output logic [`WROT_BEAT_WIDTH-1:0]         m_data,
  output logic [`WROT_USER_WIDTH-1:0]         m_user,
  output logic                                m_last
);

  localparam int AW = $clog2(`WROT_BANK_DEPTH);
  localparam int CW = $clog2(`WROT_OUT_CREDITS + 1);

  replay_state_e state;
  logic          cur_bank;
  logic [1:0]    pending;
  logic [CW-1:0] credits;
  logic          issue;
  logic          kern_end;
  logic          col_end;
  logic          all_end;
  logic [AW-1:0] addr;
  kh_t           kh_cnt;
  cin_t          cin_cnt;
  cols_t         col;
  blocks_t       blk;
  kh_t           kh_1;
  cin_t          cin_1;
  cols_t         cols_1;
  blocks_t       blocks_1;

  assign kh_1     = hdr_kh_1[cur_bank];
  assign cin_1    = hdr_cin_1[cur_bank];
  assign cols_1   = hdr_cols_1[cur_bank];
  assign blocks_1 = hdr_blocks_1[cur_bank];

  // a credit is taken when the beat is issued, not when it leaves.
  assign issue    = (credits != '0) && (state == replay_config || state == replay_run);
  assign rd_en    = issue && (state == replay_run);
  assign rd_bank  = cur_bank;
  assign rd_addr  = addr;
  assign kern_end = (kh_cnt == kh_1) && (cin_cnt == cin_1);
  assign col_end  = kern_end && (col == cols_1);
  assign all_end  = col_end && (blk == blocks_1);

  assign m_data = m_user[user_config] ? `WROT_BEAT_WIDTH'({blocks_1, cols_1, cin_1, kh_1})
                                      : rd_data;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CW'(`WROT_OUT_CREDITS);
    end else begin
      credits <= credits - CW'(issue) + CW'(m_credit);
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= replay_idle;
      cur_bank     <= 1'b0;
      pending      <= '0;
      bank_release <= '0;
      addr         <= '0;
      kh_cnt       <= '0;
      cin_cnt      <= '0;
      col          <= '0;
      blk          <= '0;
    end else begin
      bank_release <= '0;
      pending      <= pending | bank_ready;
      case (state)
        replay_idle: if (pending[cur_bank]) state <= replay_config;   // halves alternate.
        replay_config: if (issue) begin
          addr    <= '0;
          kh_cnt  <= '0;
          cin_cnt <= '0;
          col     <= '0;
          blk     <= '0;
          state   <= replay_run;
        end
        replay_run: if (issue) begin
          addr   <= addr + 1'b1;
          kh_cnt <= kh_cnt + 1'b1;
          if (kh_cnt == kh_1) begin
            kh_cnt  <= '0;
            cin_cnt <= cin_cnt + 1'b1;
          end
          if (kern_end) begin
            cin_cnt <= '0;
            addr    <= '0;   // reread the kernel for the next column.
            col     <= col + 1'b1;
          end
          if (col_end) begin
            col <= '0;
            blk <= blk + 1'b1;
          end
          if (all_end) state <= replay_release;
        end
        replay_release: begin
          bank_release[cur_bank] <= 1'b1;
          pending[cur_bank]      <= 1'b0;
          cur_bank               <= ~cur_bank;
          state                  <= replay_idle;
        end
        default: state <= replay_idle;
      endcase
    end
  end

  // flags line up with rd_data one cycle after the read.
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
      m_user  <= '0;
    end else begin
      m_valid <= issue;
      m_last  <= rd_en && all_end;
      if (issue) begin
        m_user[user_config]       <= (state == replay_config);
        m_user[user_top_block]    <= rd_en && (blk == '0);
        m_user[user_bottom_block] <= rd_en && (blk == blocks_1);
        m_user[user_cin_last]     <= rd_en && (cin_cnt == cin_1);
        m_user[user_cols_last]    <= rd_en && (col == cols_1);
      end
    end
  end

endmodule

//--- rtl/weight_loader.sv
`timescale 1ns/1ps
`include "wrot_cfg.svh"

module weight_loader
  import wrot_beat_pkg::*;
  import wrot_ctrl_pkg::*;
(
  input  logic                                aclk,
  input  logic                                rst_n,
  input  logic                                s_valid,
  input  logic [`WROT_BEAT_WIDTH-1:0]         s_data,
  output logic                                s_credit,
  output logic                                wr_en,
  output logic                                wr_bank,
  output logic [$clog2(`WROT_BANK_DEPTH)-1:0] wr_addr,
  output logic [`WROT_BEAT_WIDTH-1:0]         wr_data,
  output logic [1:0]                          bank_ready,
  output kh_t     [1:0]                       hdr_kh_1,
  output cin_t    [1:0]                       hdr_cin_1,
  output cols_t   [1:0]                       hdr_cols_1,
  output blocks_t [1:0]                       hdr_blocks_1,
  input  logic [1:0]                          bank_release
);

  localparam int AW = $clog2(`WROT_BANK_DEPTH);
  localparam int FW = $clog2(`WROT_IN_CREDITS);

  logic [`WROT_BEAT_WIDTH-1:0] fifo_mem [`WROT_IN_CREDITS];
  logic [FW-1:0]               fifo_wptr;
  logic [FW-1:0]               fifo_rptr;
  logic [FW:0]                 fifo_count;
  logic [`WROT_BEAT_WIDTH-1:0] head;
  logic                        pop;
  load_state_e                 state;
  logic                        cur_bank;
  logic                        nxt_bank;
  logic [1:0]                  full;
  logic [AW-1:0]               beat_addr;
  logic [AW-1:0]               last_addr;
  logic [AW:0]                 n_beats;
  logic                        last_beat;
  kh_t                         in_kh;
  cin_t                        in_cin;
  cols_t                       in_cols;
  blocks_t                     in_blocks;

  assign head = fifo_mem[fifo_rptr];
  assign {in_blocks, in_cols, in_cin, in_kh} =
    head[`WROT_KH_BITS+`WROT_CIN_BITS+`WROT_COLS_BITS+`WROT_BLOCKS_BITS-1:0];
  assign n_beats = (AW+1)'((32'(in_kh) + 1) * (32'(in_cin) + 1));

  assign pop       = (fifo_count != '0) && (state != load_wait_bank);
  assign s_credit  = pop;   // a freed slot goes straight back upstream.
  assign wr_en     = pop && (state == load_weights);
  assign wr_bank   = cur_bank;
  assign wr_addr   = beat_addr;
  assign wr_data   = head;
  assign last_beat = wr_en && (beat_addr == last_addr);
  assign nxt_bank  = ~cur_bank;

  always_ff @(posedge aclk) begin
    if (s_valid) begin
      fifo_mem[fifo_wptr] <= s_data;
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      fifo_wptr  <= '0;
      fifo_rptr  <= '0;
      fifo_count <= '0;
    end else begin
      if (s_valid) fifo_wptr <= fifo_wptr + 1'b1;
      if (pop) fifo_rptr <= fifo_rptr + 1'b1;
      fifo_count <= fifo_count + (FW+1)'(s_valid) - (FW+1)'(pop);
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= load_header;
      cur_bank   <= 1'b0;
      beat_addr  <= '0;
      last_addr  <= '0;
      bank_ready <= '0;
      full       <= '0;
    end else begin
      bank_ready <= last_beat ? (2'b01 << cur_bank) : 2'b00;
      full       <= (full & ~bank_release) | (last_beat ? (2'b01 << cur_bank) : 2'b00);
      case (state)
        load_header: if (pop) begin
          beat_addr <= '0;
          last_addr <= AW'(n_beats - 1'b1);
          state     <= load_weights;
        end
        load_weights: if (pop) begin
          beat_addr <= beat_addr + 1'b1;
          if (beat_addr == last_addr) begin
            cur_bank <= nxt_bank;
            state    <= (full[nxt_bank] && !bank_release[nxt_bank]) ? load_wait_bank
                                                                     : load_header;
          end
        end
        load_wait_bank: if (!full[cur_bank]) state <= load_header;
        default: state <= load_header;
      endcase
    end
  end

  // header is held per half until the replayer gives it back.
  always_ff @(posedge aclk) begin
    if (pop && state == load_header) begin
      hdr_kh_1[cur_bank]     <= in_kh;
      hdr_cin_1[cur_bank]    <= in_cin;
      hdr_cols_1[cur_bank]   <= in_cols;
      hdr_blocks_1[cur_bank] <= in_blocks;
    end
  end

endmodule

//--- rtl/weight_bank_ram.sv
`timescale 1ns/1ps
`include "wrot_cfg.svh"

module weight_bank_ram (
  input  logic                                aclk,
  input  logic                                wr_en,
  input  logic                                wr_bank,
  input  logic [$clog2(`WROT_BANK_DEPTH)-1:0] wr_addr,
  input  logic [`WROT_BEAT_WIDTH-1:0]         wr_data,
  input  logic                                rd_en,
  input  logic                                rd_bank,
  input  logic [$clog2(`WROT_BANK_DEPTH)-1:0] rd_addr,
  output logic [`WROT_BEAT_WIDTH-1:0]         rd_data
);

  localparam int AW = $clog2(`WROT_BANK_DEPTH);

  // both halves in one array, bank bit on top.
  logic [`WROT_BEAT_WIDTH-1:0] mem [2*`WROT_BANK_DEPTH];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[{wr_bank, wr_addr}] <= wr_data;
    end
  end

  // registered read, one cycle latency.
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_data <= mem[{rd_bank, rd_addr[AW-1:0]}];
    end
  end

endmodule

//--- rtl/wrot_ctrl_pkg.sv
package wrot_ctrl_pkg;

  typedef enum logic [1:0] {
    load_header,
    load_weights,
    load_wait_bank   // target half still owned by the replayer.
  } load_state_e;

  typedef enum logic [1:0] {
    replay_idle,
    replay_config,
    replay_run,
    replay_release
  } replay_state_e;

endpackage

//--- rtl/wrot_beat_pkg.sv
`include "wrot_cfg.svh"

package wrot_beat_pkg;

  // header fields, all stored as value minus one.
  typedef logic [`WROT_KH_BITS-1:0]     kh_t;
  typedef logic [`WROT_CIN_BITS-1:0]    cin_t;
  typedef logic [`WROT_COLS_BITS-1:0]   cols_t;
  typedef logic [`WROT_BLOCKS_BITS-1:0] blocks_t;

  // bit positions inside m_user.
  typedef enum logic [$clog2(`WROT_USER_WIDTH)-1:0] {
    user_config       = 0,
    user_top_block    = 1,
    user_bottom_block = 2,
    user_cin_last     = 3,
    user_cols_last    = 4
  } wrot_user_e;

endpackage

//--- rtl/wrot_cfg.svh
`ifndef WROT_CFG_SVH
`define WROT_CFG_SVH

// beat geometry.
`define WROT_CORES       4
`define WROT_KW_MAX      3
`define WROT_WORD_WIDTH  8
`define WROT_BEAT_WIDTH  (`WROT_CORES * `WROT_KW_MAX * `WROT_WORD_WIDTH)

`define WROT_BANK_DEPTH  64   // weight beats per bank half.
`define WROT_IN_CREDITS  4
`define WROT_OUT_CREDITS 4

// header field widths, kh*cin must fit in one bank.
`define WROT_KH_BITS     2
`define WROT_CIN_BITS    4
`define WROT_COLS_BITS   5
`define WROT_BLOCKS_BITS 3

`define WROT_USER_WIDTH  5

`endif
